// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mesh_tb
FILELIST = project.f
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/mesh_tb.sv ====
`include "noc_settings.svh"

module mesh_tb;
  import noc_pkg::*;

  localparam int NODES     = `NUM_NODES;
  localparam int PKTS      = 50;             // per source.
  localparam int MAX_BODY  = 6;
  localparam int CYCLE_MAX = 200 * 7 * 40;

  logic             clk;
  logic             arst_n;
  logic [NODES-1:0] in_valid;
  flit_t            in_flit [NODES];
  logic [NODES-1:0] in_full;
  logic [NODES-1:0] out_valid;
  flit_t            out_flit [NODES];
  logic [NODES-1:0] out_full;

  integer      seed;
  logic [15:0] exp_q [NODES*NODES][$];     // dest*NODES+src, packets that have a body.
  int          hdr_only [NODES];           // header-only packets still due per sink.
  logic [15:0] cur_pkt [NODES][MAX_BODY+1];
  int          cur_len [NODES];
  int          cur_idx [NODES];
  int          sent [NODES];
  int          body_left [NODES];
  int          rx_src [NODES];
  bit          rx_first [NODES];
  logic [15:0] rx_hdr [NODES];
  int          delivered;
  int          errors;
  int          cycles;
  bit          finished;

  mesh_2x2 UUT (
    .clk_i           (clk),
    .arst_n_i        (arst_n),
    .loc_in_valid_i  (in_valid),
    .loc_in_flit_i   (in_flit),
    .loc_in_full_o   (in_full),
    .loc_out_valid_o (out_valid),
    .loc_out_flit_o  (out_flit),
    .loc_out_full_i  (out_full)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  // builds the next packet of a source and books it in the model.
  task automatic new_packet(input int s);
    int dest;
    int len;
    dest = rand_below(NODES);
    len  = rand_below(MAX_BODY + 1);
    cur_pkt[s][0] = {8'(len), 4'(dest % `MESH_DIM), 4'(dest / `MESH_DIM)};
    for (int b = 1; b <= len; b++) begin
      cur_pkt[s][b] = 16'($random(seed));
    end
    if (len > 0) begin
      cur_pkt[s][1][15:14] = 2'(s);  // source tag.
    end
    cur_len[s] = len + 1;
    cur_idx[s] = 0;
    if (len == 0) begin
      hdr_only[dest]++;
    end else begin
      for (int b = 0; b <= len; b++) begin
        exp_q[dest*NODES + s].push_back(cur_pkt[s][b]);
      end
    end
  endtask

  task automatic drive_sources();
    for (int s = 0; s < NODES; s++) begin
      in_valid[s]        = 1'b0;
      in_flit[s].payload = '0;
      if (cur_idx[s] == cur_len[s] && sent[s] < PKTS) begin
        new_packet(s);
        sent[s]++;
      end
      if (cur_idx[s] < cur_len[s] && !in_full[s] && rand_below(4) != 0) begin
        in_valid[s]        = 1'b1;
        in_flit[s].payload = cur_pkt[s][cur_idx[s]];
        cur_idx[s]++;
      end
      out_full[s] = (rand_below(4) == 0);  // sink stalls about a quarter of the time.
    end
  endtask

  task automatic check_sink(input int d);
    logic [15:0] word;
    logic [15:0] want;
    logic [7:0]  here;
    int          q;
    word = out_flit[d].payload;
    here = {4'(d % `MESH_DIM), 4'(d / `MESH_DIM)};
    assert (!(out_valid[d] && out_full[d])) else begin
      $display("node %0d raised its local valid while its full input was high", d);
      errors++;
    end
    if (out_valid[d] && body_left[d] == 0) begin
      assert (word[7:0] == here) else begin
        $display("FAIL loc_out_flit_o[%0d] header dest: expected %02h, got %02h",
                 d, here, word[7:0]);
        errors++;
      end
      if (word[15:8] == 8'd0) begin
        assert (hdr_only[d] > 0) else begin
          $display("node %0d received a header-only packet that was never sent", d);
          errors++;
        end
        if (hdr_only[d] > 0) begin
          hdr_only[d]--;
        end
        delivered++;
      end else begin
        rx_hdr[d]    = word;
        body_left[d] = int'(word[15:8]);
        rx_first[d]  = 1'b1;
      end
    end else if (out_valid[d]) begin
      if (rx_first[d]) begin
        rx_src[d]   = int'(word[15:14]);
        rx_first[d] = 1'b0;
        q = d*NODES + rx_src[d];
        assert (exp_q[q].size() > 0) else begin
          $display("node %0d received a packet from node %0d that was never sent",
                   d, rx_src[d]);
          errors++;
        end
        if (exp_q[q].size() > 0) begin
          want = exp_q[q].pop_front();
          assert (rx_hdr[d] == want) else begin
            $display("FAIL loc_out_flit_o[%0d] header: expected %04h, got %04h",
                     d, want, rx_hdr[d]);
            errors++;
          end
        end
      end
      q = d*NODES + rx_src[d];
      if (exp_q[q].size() > 0) begin
        want = exp_q[q].pop_front();
        assert (word == want) else begin
          $display("FAIL loc_out_flit_o[%0d] body: expected %04h, got %04h", d, want, word);
          errors++;
        end
      end
      body_left[d]--;
      if (body_left[d] == 0) begin
        delivered++;
      end
    end
  endtask

  always @(posedge clk) begin
    if (arst_n && !finished) begin
      for (int d = 0; d < NODES; d++) begin
        check_sink(d);
      end
    end
  end

  task automatic check_drained();
    for (int d = 0; d < NODES; d++) begin
      assert (hdr_only[d] == 0) else begin
        $display("node %0d is missing %0d header-only packets", d, hdr_only[d]);
        errors++;
      end
      assert (body_left[d] == 0) else begin
        $display("node %0d stopped in the middle of a packet", d);
        errors++;
      end
      for (int s = 0; s < NODES; s++) begin
        assert (exp_q[d*NODES + s].size() == 0) else begin
          $display("%0d flits from node %0d never reached node %0d",
                   exp_q[d*NODES + s].size(), s, d);
          errors++;
        end
      end
    end
  endtask

  task automatic finish_run();
    finished = 1'b1;
    $display("mesh_tb: %0d errors, %0d of %0d packets delivered in %0d cycles",
             errors, delivered, NODES*PKTS, cycles);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  initial begin
    seed      = 32'hd06d1d58;
    errors    = 0;
    delivered = 0;
    finished  = 1'b0;
    arst_n    = 1'b0;
    in_valid  = '0;
    out_full  = '0;
    for (int n = 0; n < NODES; n++) begin
      in_flit[n].payload = '0;
      hdr_only[n]  = 0;
      cur_len[n]   = 0;
      cur_idx[n]   = 0;
      sent[n]      = 0;
      body_left[n] = 0;
      rx_src[n]    = 0;
      rx_first[n]  = 1'b0;
      rx_hdr[n]    = '0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    assert (out_valid == '0) else begin
      $display("FAIL loc_out_valid_o after reset: expected 0, got %h", out_valid);
      errors++;
    end
    assert (in_full == '0) else begin
      $display("FAIL loc_in_full_o after reset: expected 0, got %h", in_full);
      errors++;
    end
    while (delivered < NODES*PKTS) begin
      @(negedge clk);
      drive_sources();
    end
    in_valid = '0;
    out_full = '0;
    repeat (20) @(negedge clk);  // catch stray flits.
    check_drained();
    finish_run();
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_MAX) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles with %0d packets still undelivered",
             cycles, NODES*PKTS - delivered);
    errors++;
    finish_run();
  end

endmodule

// ==== hw/corner_node.sv ====
`include "noc_settings.svh"

module corner_node #(
  parameter int NODE_X = 0,
  parameter int NODE_Y = 0
) (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           vert_in_valid_i,
  input  noc_pkg::flit_t vert_in_flit_i,
  output logic           vert_in_full_o,
  output logic           vert_out_valid_o,
  output noc_pkg::flit_t vert_out_flit_o,
  input  logic           vert_out_full_i,
  input  logic           horz_in_valid_i,
  input  noc_pkg::flit_t horz_in_flit_i,
  output logic           horz_in_full_o,
  output logic           horz_out_valid_o,
  output noc_pkg::flit_t horz_out_flit_o,
  input  logic           horz_out_full_i,
  input  logic           loc_in_valid_i,
  input  noc_pkg::flit_t loc_in_flit_i,
  output logic           loc_in_full_o,
  output logic           loc_out_valid_o,
  output noc_pkg::flit_t loc_out_flit_o,
  input  logic           loc_out_full_i
);
  import noc_pkg::*;

  localparam logic [3:0] MY_Y = 4'(NODE_Y);

  logic [`NUM_PORTS-1:0] in_valid;
  logic [`NUM_PORTS-1:0] in_full;
  logic [`NUM_PORTS-1:0] pop;
  logic [`NUM_PORTS-1:0] head_valid;
  logic [`NUM_PORTS-1:0] head_is_header;
  logic [`NUM_PORTS-1:0] tail;
  logic [`NUM_PORTS-1:0] out_valid;
  logic [`NUM_PORTS-1:0] out_full;
  flit_t                 in_flit   [`NUM_PORTS];
  flit_t                 head_flit [`NUM_PORTS];
  flit_t                 out_flit  [`NUM_PORTS];
  logic [7:0]            head_dest [`NUM_PORTS];
  port_e                 out_sel   [`NUM_PORTS];

  assign in_valid[PORT_VERT]  = vert_in_valid_i;
  assign in_valid[PORT_HORZ]  = horz_in_valid_i;
  assign in_valid[PORT_LOCAL] = loc_in_valid_i;
  assign in_flit[PORT_VERT]   = vert_in_flit_i;
  assign in_flit[PORT_HORZ]   = horz_in_flit_i;
  assign in_flit[PORT_LOCAL]  = loc_in_flit_i;
  assign out_full[PORT_VERT]  = vert_out_full_i;
  assign out_full[PORT_HORZ]  = horz_out_full_i;
  assign out_full[PORT_LOCAL] = loc_out_full_i;

  assign vert_in_full_o   = in_full[PORT_VERT];
  assign horz_in_full_o   = in_full[PORT_HORZ];
  assign loc_in_full_o    = in_full[PORT_LOCAL];
  assign vert_out_valid_o = out_valid[PORT_VERT];
  assign horz_out_valid_o = out_valid[PORT_HORZ];
  assign loc_out_valid_o  = out_valid[PORT_LOCAL];
  assign vert_out_flit_o  = out_flit[PORT_VERT];
  assign horz_out_flit_o  = out_flit[PORT_HORZ];
  assign loc_out_flit_o   = out_flit[PORT_LOCAL];

  for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_in
    flit_fifo u_fifo (
      .clk_i,
      .arst_n_i,
      .push_i       (in_valid[i]),
      .flit_i       (in_flit[i]),
      .pop_i        (pop[i]),
      .full_o       (in_full[i]),
      .head_valid_o (head_valid[i]),
      .head_flit_o  (head_flit[i])
    );

    packet_tracker u_track (
      .clk_i,
      .arst_n_i,
      .head_valid_i     (head_valid[i]),
      .head_flit_i      (head_flit[i]),
      .pop_i            (pop[i]),
      .head_is_header_o (head_is_header[i]),
      .head_dest_o      (head_dest[i]),
      .tail_o           (tail[i])
    );
  end

  switch_ctrl #(.NODE_X(NODE_X), .NODE_Y(NODE_Y)) u_ctrl (
    .clk_i,
    .arst_n_i,
    .head_valid_i     (head_valid),
    .head_is_header_i (head_is_header),
    .head_dest_i      (head_dest),
    .tail_i           (tail),
    .out_full_i       (out_full),
    .pop_o            (pop),
    .out_valid_o      (out_valid),
    .out_sel_o        (out_sel)
  );

  // crossbar, idle outputs carry zero.
  always_comb begin
    for (int o = 0; o < `NUM_PORTS; o++) begin
      out_flit[o] = out_valid[o] ? head_flit[out_sel[o]] : '0;
    end
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid[PORT_VERT] && head_is_header[out_sel[PORT_VERT]] |->
      (`BOTTOM(NODE_Y) ? head_dest[out_sel[PORT_VERT]][3:0] > MY_Y
                       : `TOP(NODE_Y) && head_dest[out_sel[PORT_VERT]][3:0] < MY_Y))
    else $error("corner_node: header sent north or south off the mesh");

endmodule

// ==== hw/flit_fifo.sv ====
`include "noc_settings.svh"

module flit_fifo (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           push_i,
  input  noc_pkg::flit_t flit_i,
  input  logic           pop_i,
  output logic           full_o,
  output logic           head_valid_o,
  output noc_pkg::flit_t head_flit_o
);
  import noc_pkg::*;

  localparam int PTR_W = $clog2(`FIFO_DEPTH);
  localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

  flit_t            mem [`FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  assign full_o       = (count_q == CNT_W'(`FIFO_DEPTH));
  assign head_valid_o = (count_q != '0);
  assign head_flit_o  = mem[rd_ptr_q];  // look-ahead, no read latency.

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= flit_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // idle, or push and pop together.
      endcase
    end
  end

  // the upstream sender must respect the full level.
  assert property (@(posedge clk_i) disable iff (!arst_n_i) push_i |-> !full_o)
    else $error("flit_fifo: push while full");

  // the switch may only pop a flit that is there.
  assert property (@(posedge clk_i) disable iff (!arst_n_i) pop_i |-> head_valid_o)
    else $error("flit_fifo: pop while empty");

endmodule

// ==== hw/mesh_2x2.sv ====
`include "noc_settings.svh"

module mesh_2x2 (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic [`NUM_NODES-1:0] loc_in_valid_i,
  input  noc_pkg::flit_t        loc_in_flit_i [`NUM_NODES],
  output logic [`NUM_NODES-1:0] loc_in_full_o,
  output logic [`NUM_NODES-1:0] loc_out_valid_o,
  output noc_pkg::flit_t        loc_out_flit_o [`NUM_NODES],
  input  logic [`NUM_NODES-1:0] loc_out_full_i
);
  import noc_pkg::*;

  // each index is the node that drives the signal.
  logic [`NUM_NODES-1:0] vert_valid;
  logic [`NUM_NODES-1:0] vert_full;   // full level of the vertical input.
  logic [`NUM_NODES-1:0] horz_valid;
  logic [`NUM_NODES-1:0] horz_full;
  flit_t                 vert_flit [`NUM_NODES];
  flit_t                 horz_flit [`NUM_NODES];

  for (genvar y = 0; y < `MESH_DIM; y++) begin : g_row
    for (genvar x = 0; x < `MESH_DIM; x++) begin : g_col
      localparam int ID   = y * `MESH_DIM + x;
      localparam int H_ID = y * `MESH_DIM + (`MESH_DIM - 1 - x);  // east or west peer.
      localparam int V_ID = (`MESH_DIM - 1 - y) * `MESH_DIM + x;  // north or south peer.

      corner_node #(.NODE_X(x), .NODE_Y(y)) u_node (
        .clk_i,
        .arst_n_i,
        .vert_in_valid_i  (vert_valid[V_ID]),
        .vert_in_flit_i   (vert_flit[V_ID]),
        .vert_in_full_o   (vert_full[ID]),
        .vert_out_valid_o (vert_valid[ID]),
        .vert_out_flit_o  (vert_flit[ID]),
        .vert_out_full_i  (vert_full[V_ID]),
        .horz_in_valid_i  (horz_valid[H_ID]),
        .horz_in_flit_i   (horz_flit[H_ID]),
        .horz_in_full_o   (horz_full[ID]),
        .horz_out_valid_o (horz_valid[ID]),
        .horz_out_flit_o  (horz_flit[ID]),
        .horz_out_full_i  (horz_full[H_ID]),
        .loc_in_valid_i   (loc_in_valid_i[ID]),
        .loc_in_flit_i    (loc_in_flit_i[ID]),
        .loc_in_full_o    (loc_in_full_o[ID]),
        .loc_out_valid_o  (loc_out_valid_o[ID]),
        .loc_out_flit_o   (loc_out_flit_o[ID]),
        .loc_out_full_i   (loc_out_full_i[ID])
      );
    end
  end

endmodule

// ==== hw/noc_pkg.sv ====
`include "noc_settings.svh"

package noc_pkg;

  // header word as seen by the routers.
  typedef struct packed {
    logic [7:0] len;     // body flits that follow.
    logic [3:0] dest_x;
    logic [3:0] dest_y;
  } hdr_t;

  // one link word, either a header or plain payload.
  typedef union packed {
    hdr_t              hdr;
    logic [`FLIT_W-1:0] payload;
  } flit_t;

  // port index inside a corner node.
  typedef enum logic [1:0] {
    PORT_VERT  = 2'd0,   // north or south neighbour.
    PORT_HORZ  = 2'd1,   // east or west neighbour.
    PORT_LOCAL = 2'd2
  } port_e;

endpackage

// ==== hw/noc_settings.svh ====
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

`define FLIT_W      16
`define FIFO_DEPTH  4
`define MESH_DIM    2

`define NUM_PORTS   3                        // vertical, horizontal, local.
`define NUM_NODES   (`MESH_DIM * `MESH_DIM)

// position of a node on the mesh border.
`define TOP(y)      ((y) == `MESH_DIM - 1)
`define BOTTOM(y)   ((y) == 0)
`define LEFT(x)     ((x) == 0)
`define RIGHT(x)    ((x) == `MESH_DIM - 1)

`endif

// ==== hw/packet_tracker.sv ====
module packet_tracker (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           head_valid_i,
  input  noc_pkg::flit_t head_flit_i,
  input  logic           pop_i,
  output logic           head_is_header_o,
  output logic [7:0]     head_dest_o,
  output logic           tail_o
);

  logic [7:0] remain_q;  // body flits still to pass.
  logic [7:0] dest_q;
  logic [7:0] hdr_dest;

  assign hdr_dest = {head_flit_i.hdr.dest_x, head_flit_i.hdr.dest_y};

  // nothing left of the last packet, so the head opens a new one.
  assign head_is_header_o = head_valid_i && (remain_q == '0);

  assign head_dest_o = head_is_header_o ? hdr_dest : dest_q;

  always_comb begin
    if (!head_valid_i) begin
      tail_o = 1'b0;
    end else if (head_is_header_o) begin
      tail_o = (head_flit_i.hdr.len == '0);  // header-only packet.
    end else begin
      tail_o = (remain_q == 8'd1);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      remain_q <= '0;
    end else if (pop_i) begin
      if (remain_q == '0) begin
        remain_q <= head_flit_i.hdr.len;
      end else begin
        remain_q <= remain_q - 1'b1;
      end
    end
  end

  // destination of the packet in flight.
  always_ff @(posedge clk_i) begin
    if (pop_i && remain_q == '0) begin
      dest_q <= hdr_dest;
    end
  end

endmodule

// ==== hw/switch_ctrl.sv ====
`include "noc_settings.svh"

module switch_ctrl #(
  parameter int NODE_X = 0,
  parameter int NODE_Y = 0
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic [`NUM_PORTS-1:0] head_valid_i,
  input  logic [`NUM_PORTS-1:0] head_is_header_i,
  input  logic [7:0]            head_dest_i [`NUM_PORTS],
  input  logic [`NUM_PORTS-1:0] tail_i,
  input  logic [`NUM_PORTS-1:0] out_full_i,
  output logic [`NUM_PORTS-1:0] pop_o,
  output logic [`NUM_PORTS-1:0] out_valid_o,
  output noc_pkg::port_e        out_sel_o [`NUM_PORTS]
);
  import noc_pkg::*;

  localparam logic [3:0] MY_X = 4'(NODE_X);
  localparam logic [3:0] MY_Y = 4'(NODE_Y);

  port_e                 route   [`NUM_PORTS];  // wanted output of each input.
  port_e                 winner  [`NUM_PORTS];
  port_e                 owner_q [`NUM_PORTS];
  port_e                 rr_q    [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] lock_q;
  logic [`NUM_PORTS-1:0] win_found;
  logic [`NUM_PORTS-1:0] in_grant [`NUM_PORTS];  // outputs granted to each input.

  // XY routing takes x first.
  always_comb begin
    for (int i = 0; i < `NUM_PORTS; i++) begin
      if (head_dest_i[i][7:4] != MY_X) begin
        route[i] = PORT_HORZ;
      end else if (head_dest_i[i][3:0] != MY_Y) begin
        route[i] = PORT_VERT;
      end else begin
        route[i] = PORT_LOCAL;
      end
    end
  end

  // round-robin among fresh headers, starting at the pointer.
  always_comb begin
    int idx;
    for (int o = 0; o < `NUM_PORTS; o++) begin
      win_found[o] = 1'b0;
      winner[o]    = rr_q[o];
      for (int k = 0; k < `NUM_PORTS; k++) begin
        idx = (int'(rr_q[o]) + k) % `NUM_PORTS;
        if (!win_found[o] && head_valid_i[idx] && head_is_header_i[idx] &&
            route[idx] == port_e'(o)) begin
          win_found[o] = 1'b1;
          winner[o]    = port_e'(idx);
        end
      end
    end
  end

  always_comb begin
    pop_o = '0;
    for (int i = 0; i < `NUM_PORTS; i++) begin
      in_grant[i] = '0;
    end
    for (int o = 0; o < `NUM_PORTS; o++) begin
      out_sel_o[o]   = lock_q[o] ? owner_q[o] : winner[o];
      out_valid_o[o] = (lock_q[o] || win_found[o]) && head_valid_i[out_sel_o[o]] &&
                       !out_full_i[o];
      if (out_valid_o[o]) begin
        pop_o[out_sel_o[o]]       = 1'b1;
        in_grant[out_sel_o[o]][o] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lock_q <= '0;
      for (int o = 0; o < `NUM_PORTS; o++) begin
        owner_q[o] <= PORT_VERT;
        rr_q[o]    <= PORT_VERT;
      end
    end else begin
      for (int o = 0; o < `NUM_PORTS; o++) begin
        if (out_valid_o[o]) begin
          lock_q[o]  <= !tail_i[out_sel_o[o]];  // held until the tail goes.
          owner_q[o] <= out_sel_o[o];
          if (!lock_q[o]) begin
            rr_q[o] <= (winner[o] == PORT_LOCAL) ? PORT_VERT : port_e'(winner[o] + 2'd1);
          end
        end
      end
    end
  end

  for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_grant_chk
    assert property (@(posedge clk_i) disable iff (!arst_n_i) $onehot0(in_grant[i]))
      else $error("switch_ctrl: input %0d granted to two outputs", i);
  end

  // headers sent east or west must aim at the neighbour column.
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o[PORT_HORZ] && !lock_q[PORT_HORZ] |->
      (`LEFT(NODE_X) ? head_dest_i[out_sel_o[PORT_HORZ]][7:4] > MY_X
                     : `RIGHT(NODE_X) && head_dest_i[out_sel_o[PORT_HORZ]][7:4] < MY_X))
    else $error("switch_ctrl: header routed off the mesh");

endmodule

// ==== project.f ====
+incdir+hw
hw/noc_pkg.sv
hw/flit_fifo.sv
hw/packet_tracker.sv
hw/switch_ctrl.sv
hw/corner_node.sv
hw/mesh_2x2.sv
bench/mesh_tb.sv
